//--- build.f
+incdir+design
design/cpu_pkg.sv
design/alu.sv
design/reg_file.sv
design/pointer_pair.sv
design/control_unit.sv
design/cpu.sv
dv/cpu_properties.sv
dv/tb_cpu.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := All checks passed

SOURCES := $(shell grep -v '^+' $(FILELIST)) design/cpu_config.svh

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search the log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIM_ARGS"

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "test FAILED, see $(LOG)"; exit 1; }
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/tb_cpu.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_config.svh"

module tb_cpu;
    import cpu_pkg::*;

    logic  nclk;
    logic  rst;
    data_t rdata;
    addr_t addr;
    data_t wdata;
    logic  oe;
    logic  we;
    logic  halted;

    data_t       mem [1 << `CPU_ADDR_W];
    logic [31:0] lfsr = 32'h7af5dde5;
    addr_t       pc;      // next program byte
    addr_t       dp;      // model of the data pointer
    data_t       ra;
    data_t       rb;
    logic        fz;
    logic        fc;
    int          n_instr = 0;
    int          errors = 0;
    int          n_stores = 0;
    int          cycles = 0;
    int          limit = 0;
    logic        fetch_seen = 1'b0;
    logic        halt_seen = 1'b0;
    addr_t       exp_addr [$];
    data_t       exp_data [$];

    cpu cpu_i (
        .nclk   (nclk),
        .rst    (rst),
        .rdata  (rdata),
        .addr   (addr),
        .wdata  (wdata),
        .oe     (oe),
        .we     (we),
        .halted (halted)
    );

    always #4 nclk = ~nclk;

    assign rdata = mem[addr]; // asynchronous sram read

    always @(posedge nclk) begin
        if (we) begin
            mem[addr] = wdata;
        end
    end

    task automatic log_error(input string msg);
        errors++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    // galois lfsr, one step per bit taken
    function automatic data_t rand_byte();
        data_t v;
        v = '0;
        for (int i = 0; i < `CPU_DATA_W; i++) begin
            v = {v[`CPU_DATA_W-2:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic addr_t rand_store_addr();
        data_t hi;
        data_t lo;
        hi = rand_byte() | 8'h80; // above code and load data
        lo = rand_byte();
        return {hi, lo};
    endfunction

    task automatic put_byte(input data_t v);
        mem[pc] = v;
        pc++;
    endtask

    task automatic put_op(input data_t v);
        put_byte(v);
        n_instr++;
    endtask

    task automatic load_a_imm(input data_t v);
        put_op(OP_LDI_A);
        put_byte(v);
        ra = v;
    endtask

    task automatic load_b_imm(input data_t v);
        put_op(OP_LDI_B);
        put_byte(v);
        rb = v;
    endtask

    task automatic copy_a_to_b();
        put_op(OP_MOV);
        rb = ra;
    endtask

    task automatic point_dp(input addr_t p);
        load_a_imm(p[`CPU_DATA_W-1:0]);
        put_op(OP_PL);
        load_a_imm(p[`CPU_ADDR_W-1:`CPU_DATA_W]);
        put_op(OP_PH);
        dp = p;
    endtask

    task automatic store_a();
        put_op(OP_ST);
        exp_addr.push_back(dp);
        exp_data.push_back(ra);
    endtask

    task automatic run_alu(input alu_op_t op);
        int   sum;
        logic cy;
        put_op(OP_ALU_BASE | data_t'(op));
        cy = 1'b0;
        case (op)
            ALU_ADD: sum = int'(ra) + int'(rb);
            ALU_ADC: sum = int'(ra) + int'(rb) + int'(fc);
            ALU_SUB: begin
                sum = int'(ra) - int'(rb);
                cy  = (ra < rb); // borrow
            end
            ALU_AND: sum = int'(ra & rb);
            ALU_OR:  sum = int'(ra | rb);
            default: sum = int'(ra ^ rb);
        endcase
        if (op == ALU_ADD || op == ALU_ADC) begin
            cy = (sum >= (1 << `CPU_DATA_W));
        end
        ra = data_t'(sum);
        fz = (ra == '0);
        fc = cy;
    endtask

    task automatic swap_ptrs(input logic cond);
        addr_t t;
        if (cond) begin
            t  = pc;
            pc = dp;
            dp = t;
        end
    endtask

    task automatic build_program();
        data_t x;
        data_t y;
        addr_t src;
        for (int i = 0; i < (1 << `CPU_ADDR_W); i++) begin
            mem[addr_t'(i)] = data_t'(i ^ (i >> 8));
        end
        pc = `CPU_RESET_IP;
        dp = `CPU_RESET_IP;
        ra = '0;
        rb = '0;
        fz = 1'b0;
        fc = 1'b0;
        put_op(OP_NOP);
        put_op(8'h77); // undefined, runs as nop
        x = rand_byte() | 8'h80;
        load_a_imm(x);
        put_op(OP_PL);
        put_op(OP_PH);
        dp = {x, x};
        store_a();
        for (int r = 0; r < 3; r++) begin
            for (int k = 0; k <= int'(ALU_XOR); k++) begin
                x = rand_byte();
                y = rand_byte();
                if (r == 0) begin
                    x = x | 8'h80; // add always carries
                    y = y | 8'h80;
                end
                point_dp(rand_store_addr());
                if (r == 1) begin
                    load_b_imm(y);
                end else begin
                    load_a_imm(y);
                    copy_a_to_b();
                end
                load_a_imm(x);
                run_alu(alu_op_t'(k));
                store_a();
                if (alu_op_t'(k) == ALU_ADD) begin
                    run_alu(ALU_ADC);
                    store_a();
                end
            end
        end
        src = {8'h70, rand_byte()};
        mem[src] = rand_byte();
        point_dp(src);
        put_op(OP_LD);
        ra = mem[src];
        copy_a_to_b();
        point_dp(rand_store_addr());
        load_a_imm(8'h00);
        run_alu(ALU_OR); // b back into a
        store_a();
        point_dp(16'h4000);
        put_op(OP_SWP);
        swap_ptrs(1'b1);
        point_dp(16'h5000);
        x = rand_byte();
        load_a_imm(x);
        copy_a_to_b();
        run_alu(ALU_SUB);
        put_op(OP_SWPZ);
        mem[pc] = OP_HLT; // only reached by a missed swap
        swap_ptrs(fz);
        point_dp(rand_store_addr());
        load_a_imm(8'hC3);
        store_a();
        point_dp(16'h6000);
        mem[16'h6000] = OP_HLT; // only reached by a wrong swap
        load_a_imm(x);
        copy_a_to_b();
        load_a_imm(x ^ 8'h5A);
        run_alu(ALU_SUB);
        put_op(OP_SWPZ);
        swap_ptrs(fz);
        point_dp(rand_store_addr());
        load_a_imm(8'h3C);
        store_a();
        put_op(OP_HLT);
    endtask

    task automatic check_store();
        assert (exp_addr.size() > 0)
            else log_error($sformatf("unexpected store of %h at %h", wdata, addr));
        if (exp_addr.size() > 0) begin
            assert (addr == exp_addr[0] && wdata == exp_data[0])
                else log_error($sformatf("store %h at %h, expected %h at %h",
                                         wdata, addr, exp_data[0], exp_addr[0]));
            void'(exp_addr.pop_front());
            void'(exp_data.pop_front());
            n_stores++;
        end
    endtask

    always @(negedge nclk) begin
        assert (!(oe && we)) else log_error("oe and we high together");
        if (!rst) begin
            assert (!oe && !we) else log_error("memory strobe during reset");
        end
        if (halt_seen) begin
            assert (halted && !oe && !we) else log_error("activity after halt");
        end
        if (oe && !fetch_seen) begin
            assert (addr == `CPU_RESET_IP)
                else log_error($sformatf("first fetch at %h", addr));
            fetch_seen = 1'b1;
        end
        if (we) begin
            check_store();
        end
        halt_seen = halt_seen || halted;
    end

    always @(posedge nclk) begin
        if (rst && !halted) begin
            cycles++;
            if (cycles > limit) begin
                $display("Timeout: the program never halted within %0d cycles", limit);
                $display("Checks failed");
                $finish;
            end
        end
    end

    initial begin
        nclk = 1'b0;
        rst  = 1'b0;
        build_program();
        limit = 2 * n_instr + 20;
        repeat (2) @(posedge nclk);
        #1 rst = 1'b1;
        wait (halted);
        repeat (4) @(posedge nclk);
        assert (exp_addr.size() == 0)
            else log_error($sformatf("%0d expected stores never seen", exp_addr.size()));
        $display("Closing: %0d stores checked, %0d errors", n_stores, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/cpu_properties.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_properties (
    input logic nclk,
    input logic rst,
    input logic oe,
    input logic we,
    input logic halted
);

    // memory sees one strobe at most
    strobe_exclusive: assert property (
        @(posedge nclk) disable iff (!rst) !(oe && we)
    ) else $error("oe and we high in the same cycle");

    reset_quiet: assert property (
        @(posedge nclk) !rst |-> (!oe && !we)
    ) else $error("memory strobe while in reset");

    halt_quiet: assert property (
        @(posedge nclk) disable iff (!rst) halted |-> (!oe && !we)
    ) else $error("memory strobe while halted");

    // only reset leaves halt
    halt_sticky: assert property (
        @(posedge nclk) disable iff (!rst) halted |=> halted
    ) else $error("halted dropped without reset");

endmodule

bind cpu cpu_properties cpu_properties_i (
    .nclk   (nclk),
    .rst    (rst),
    .oe     (oe),
    .we     (we),
    .halted (halted)
);

`default_nettype wire

//--- design/cpu.sv
`timescale 1ns/100ps
`default_nettype none

module cpu (
    input  logic           nclk,
    input  logic           rst,
    input  cpu_pkg::data_t rdata,
    output cpu_pkg::addr_t addr,
    output cpu_pkg::data_t wdata,
    output logic           oe,
    output logic           we,
    output logic           halted
);
    import cpu_pkg::*;

    data_t   ir;
    data_t   a;
    data_t   b;
    flags_t  flags;
    data_t   alu_result;
    logic    alu_z;
    logic    alu_c;
    alu_op_t alu_op;
    logic    ir_we;
    logic    a_we;
    logic    b_we;
    logic    flags_we;
    logic    a_sel;
    logic    ip_inc;
    logic    use_dp;
    logic    swap;
    logic    pl_we;
    logic    ph_we;

    assign wdata = a; // only A is ever stored

    reg_file u_reg_file (
        .nclk       (nclk),
        .rst        (rst),
        .rdata      (rdata),
        .alu_result (alu_result),
        .alu_z      (alu_z),
        .alu_c      (alu_c),
        .ir_we      (ir_we),
        .a_we       (a_we),
        .b_we       (b_we),
        .flags_we   (flags_we),
        .a_sel      (a_sel),
        .ir         (ir),
        .a          (a),
        .b          (b),
        .flags      (flags)
    );

    pointer_pair u_pointer_pair (
        .nclk   (nclk),
        .rst    (rst),
        .a      (a),
        .ip_inc (ip_inc),
        .use_dp (use_dp),
        .swap   (swap),
        .pl_we  (pl_we),
        .ph_we  (ph_we),
        .addr   (addr)
    );

    alu u_alu (
        .a        (a),
        .b        (b),
        .op       (alu_op),
        .carry_in (flags[FLAG_C]),
        .result   (alu_result),
        .z        (alu_z),
        .c        (alu_c)
    );

    control_unit u_control_unit (
        .nclk     (nclk),
        .rst      (rst),
        .ir       (ir),
        .flags    (flags),
        .ir_we    (ir_we),
        .a_we     (a_we),
        .b_we     (b_we),
        .flags_we (flags_we),
        .a_sel    (a_sel),
        .alu_op   (alu_op),
        .ip_inc   (ip_inc),
        .use_dp   (use_dp),
        .swap     (swap),
        .pl_we    (pl_we),
        .ph_we    (ph_we),
        .oe       (oe),
        .we       (we),
        .halted   (halted)
    );

endmodule

`default_nettype wire

//--- design/control_unit.sv
`timescale 1ns/100ps
`default_nettype none

module control_unit (
    input  logic             nclk,
    input  logic             rst,
    input  cpu_pkg::data_t   ir,
    input  cpu_pkg::flags_t  flags,
    output logic             ir_we,
    output logic             a_we,
    output logic             b_we,
    output logic             flags_we,
    output logic             a_sel,
    output cpu_pkg::alu_op_t alu_op,
    output logic             ip_inc,
    output logic             use_dp,
    output logic             swap,
    output logic             pl_we,
    output logic             ph_we,
    output logic             oe,
    output logic             we,
    output logic             halted
);
    import cpu_pkg::*;

    // idle is only held in reset, so strobes stay low until release
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FETCH,
        ST_EXEC,
        ST_HALT
    } state_t;

    state_t state;
    state_t state_nxt;
    logic   is_alu;

    assign is_alu = (ir[7:3] == OP_ALU_BASE[7:3]) && (ir[2:0] <= ALU_XOR);
    assign alu_op = alu_op_t'(ir[2:0]);
    assign halted = (state == ST_HALT);

    always_ff @(posedge nclk or negedge rst) begin
        if (!rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        case (state)
            ST_IDLE:  state_nxt = ST_FETCH;
            ST_FETCH: state_nxt = ST_EXEC;
            ST_EXEC:  state_nxt = (ir == OP_HLT) ? ST_HALT : ST_FETCH;
            default:  state_nxt = ST_HALT; // halt holds until reset
        endcase
    end

    always_comb begin
        ir_we    = 1'b0;
        a_we     = 1'b0;
        b_we     = 1'b0;
        flags_we = 1'b0;
        a_sel    = 1'b0;
        ip_inc   = 1'b0;
        use_dp   = 1'b0;
        swap     = 1'b0;
        pl_we    = 1'b0;
        ph_we    = 1'b0;
        oe       = 1'b0;
        we       = 1'b0;
        case (state)
            ST_FETCH: begin
                oe     = 1'b1;
                ir_we  = 1'b1;
                ip_inc = 1'b1;
            end
            ST_EXEC: begin
                if (is_alu) begin
                    a_we     = 1'b1;
                    flags_we = 1'b1;
                end else begin
                    case (ir)
                        OP_SWP:  swap = 1'b1;
                        OP_SWPZ: swap = flags[FLAG_Z];
                        OP_LDI_A: begin
                            oe     = 1'b1;
                            ip_inc = 1'b1;
                            a_sel  = 1'b1;
                            a_we   = 1'b1;
                        end
                        OP_LDI_B: begin
                            oe     = 1'b1;
                            ip_inc = 1'b1;
                            a_sel  = 1'b1;
                            b_we   = 1'b1;
                        end
                        OP_LD: begin
                            oe     = 1'b1;
                            use_dp = 1'b1;
                            a_sel  = 1'b1;
                            a_we   = 1'b1;
                        end
                        OP_ST: begin
                            we     = 1'b1;
                            use_dp = 1'b1;
                        end
                        OP_MOV:  b_we  = 1'b1; // b <- a
                        OP_PL:   pl_we = 1'b1;
                        OP_PH:   ph_we = 1'b1;
                        default: ; // nop, hlt and unknown codes
                    endcase
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- design/pointer_pair.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_config.svh"

module pointer_pair (
    input  logic           nclk,
    input  logic           rst,
    input  cpu_pkg::data_t a,
    input  logic           ip_inc,
    input  logic           use_dp,
    input  logic           swap,
    input  logic           pl_we,
    input  logic           ph_we,
    output cpu_pkg::addr_t addr
);
    import cpu_pkg::*;

    addr_t ptr [2];
    logic  sel; // index of the pointer acting as ip
    addr_t ip;
    addr_t dp;

    assign ip = ptr[sel];
    assign dp = ptr[~sel];

    assign addr = use_dp ? dp : ip;

    // both pointers share the same update rules, role set by sel
    always_ff @(posedge nclk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < 2; i++) begin
                ptr[i] <= `CPU_RESET_IP;
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (i[0] == sel) begin
                    if (ip_inc) begin
                        ptr[i] <= ptr[i] + addr_t'(1);
                    end
                end else begin
                    if (pl_we) begin
                        ptr[i][`CPU_DATA_W-1:0] <= a;
                    end
                    if (ph_we) begin
                        ptr[i][`CPU_ADDR_W-1:`CPU_DATA_W] <= a;
                    end
                end
            end
        end
    end

    always_ff @(posedge nclk or negedge rst) begin
        if (!rst) begin
            sel <= 1'b0;
        end else if (swap) begin
            sel <= ~sel; // ip and dp trade roles
        end
    end

endmodule

`default_nettype wire

//--- design/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  logic            nclk,
    input  logic            rst,
    input  cpu_pkg::data_t  rdata,
    input  cpu_pkg::data_t  alu_result,
    input  logic            alu_z,
    input  logic            alu_c,
    input  logic            ir_we,
    input  logic            a_we,
    input  logic            b_we,
    input  logic            flags_we,
    input  logic            a_sel,
    output cpu_pkg::data_t  ir,
    output cpu_pkg::data_t  a,
    output cpu_pkg::data_t  b,
    output cpu_pkg::flags_t flags
);
    import cpu_pkg::*;

    data_t a_d;
    data_t b_d;

    // a_sel picks memory for both A and B, else ALU / A
    assign a_d = a_sel ? rdata : alu_result;
    assign b_d = a_sel ? rdata : a;

    always_ff @(posedge nclk or negedge rst) begin
        if (!rst) begin
            ir <= '0;
        end else if (ir_we) begin
            ir <= rdata;
        end
    end

    always_ff @(posedge nclk or negedge rst) begin
        if (!rst) begin
            a <= '0;
        end else if (a_we) begin
            a <= a_d;
        end
    end

    always_ff @(posedge nclk or negedge rst) begin
        if (!rst) begin
            b <= '0;
        end else if (b_we) begin
            b <= b_d; // MOV or LDI B
        end
    end

    always_ff @(posedge nclk or negedge rst) begin
        if (!rst) begin
            flags <= '0;
        end else if (flags_we) begin
            flags[FLAG_Z] <= alu_z;
            flags[FLAG_C] <= alu_c;
        end
    end

endmodule

`default_nettype wire

//--- design/alu.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_config.svh"

module alu (
    input  cpu_pkg::data_t   a,
    input  cpu_pkg::data_t   b,
    input  cpu_pkg::alu_op_t op,
    input  logic             carry_in,
    output cpu_pkg::data_t   result,
    output logic             z,
    output logic             c
);
    import cpu_pkg::*;

    logic [`CPU_DATA_W:0] wide; // msb is carry or borrow

    always_comb begin
        case (op)
            ALU_ADD: begin
                wide = {1'b0, a} + {1'b0, b};
            end
            ALU_ADC: begin
                wide = {1'b0, a} + {1'b0, b} + {{`CPU_DATA_W{1'b0}}, carry_in};
            end
            ALU_SUB: begin
                wide = {1'b0, a} - {1'b0, b}; // wraps into msb when a < b
            end
            ALU_AND: begin
                wide = {1'b0, a & b};
            end
            ALU_OR: begin
                wide = {1'b0, a | b};
            end
            ALU_XOR: begin
                wide = {1'b0, a ^ b};
            end
            default: begin
                wide = {1'b0, a}; // unused codes pass a
            end
        endcase
    end

    assign result = wide[`CPU_DATA_W-1:0];
    assign c      = wide[`CPU_DATA_W];
    assign z      = (result == '0);

endmodule

`default_nettype wire

//--- design/cpu_pkg.sv
`default_nettype none

`include "cpu_config.svh"

package cpu_pkg;
    typedef logic [`CPU_DATA_W-1:0] data_t;
    typedef logic [`CPU_ADDR_W-1:0] addr_t;
    typedef logic [1:0]             flags_t;  // bit 0 z, bit 1 c
    typedef logic [2:0]             alu_op_t; // low bits of 0x3_ opcodes

    localparam int FLAG_Z = 0;
    localparam int FLAG_C = 1;

    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_ADC = 3'd1;
    localparam alu_op_t ALU_SUB = 3'd2;
    localparam alu_op_t ALU_AND = 3'd3;
    localparam alu_op_t ALU_OR  = 3'd4;
    localparam alu_op_t ALU_XOR = 3'd5;

    localparam data_t OP_NOP      = 8'h00;
    localparam data_t OP_SWP      = 8'h01;
    localparam data_t OP_SWPZ     = 8'h02;
    localparam data_t OP_HLT      = 8'h0F;
    localparam data_t OP_LDI_A    = 8'h10;
    localparam data_t OP_LDI_B    = 8'h11;
    localparam data_t OP_LD       = 8'h20;
    localparam data_t OP_ST       = 8'h21;
    localparam data_t OP_MOV      = 8'h22;
    localparam data_t OP_ALU_BASE = 8'h30; // 0x30..0x35, op in low bits
    localparam data_t OP_PL       = 8'h40;
    localparam data_t OP_PH       = 8'h41;
endpackage

`default_nettype wire

//--- design/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// data bus and register width
`define CPU_DATA_W 8

// memory address width
`define CPU_ADDR_W 16

// first fetch address after reset
`define CPU_RESET_IP 16'h0000

`endif
